//--- common/merge_pkg.sv
package merge_pkg;

   localparam int KEY_W = 32;                  // width of one sort key
   localparam int N_LANES = 4;                 // input lanes feeding the two leaf mergers

   // every FIFO of the tree has the same depth
   // merger FIFO C needs at least two entries per level below it plus one
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW = $clog2(FIFO_DEPTH); // pointer width, depth is a power of two

   // zero is reserved as the end-of-run marker
   typedef logic [KEY_W-1:0] key_t;

   // FIFO state as seen by its reader and its writer
   typedef struct packed {
      logic empty;
      logic full;
   } fifo_stat_t;

   // decision that the control hands to the compare network
   typedef struct packed {
      logic take_a;                            // route head A, else head B
      logic stall;                             // no word leaves the input FIFOs this cycle
      logic run_end;                           // both heads are zero, one zero goes out
   } merge_ctrl_t;

endpackage

//--- design/sort_fifo.sv
module sort_fifo
   import merge_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_rst_n,
   input  logic       i_enq,
   input  key_t       i_data,
   input  logic       i_deq,
   output key_t       o_data,
   output fifo_stat_t o_stat
);

   key_t               mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW:0]   count;
   logic               is_empty;
   logic               is_full;
   logic               do_enq;
   logic               do_deq;

   assign is_empty = (count == '0);
   assign is_full = (count == (FIFO_AW + 1)'(FIFO_DEPTH));

   // a read of an empty FIFO or a write to a full one is dropped
   assign do_deq = i_deq && !is_empty;
   assign do_enq = i_enq && !is_full;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_enq) begin
            wr_ptr <= wr_ptr + 1'b1;           // wraps on its own since the depth is a power of two
         end
         if (do_deq) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_enq, do_deq})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;           // both or neither leave the fill level alone
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (do_enq) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // show-ahead, the head is valid whenever the FIFO is not empty
   assign o_data = mem[rd_ptr];

   assign o_stat.empty = is_empty;
   assign o_stat.full  = is_full;

endmodule

//--- merger/merge_control.sv
module merge_control
   import merge_pkg::*;
(
   input  logic        i_clk,
   input  logic        i_rst_n,
   input  key_t        i_head_a,
   input  key_t        i_head_b,
   input  fifo_stat_t  i_stat_a,
   input  fifo_stat_t  i_stat_b,
   input  fifo_stat_t  i_stat_c,
   input  logic        i_ready_q,
   output merge_ctrl_t o_ctrl,
   output logic        o_deq_a,
   output logic        o_deq_b
);

   logic               a_zero;
   logic               b_zero;
   logic               a_lte_b;
   logic               both_avail;
   logic               run_end;
   logic               take_a;
   logic               stall;
   logic               near_full;
   logic               s1_busy;                // word in network stage 1
   logic               s2_busy;                // word in network stage 2, written into C now
   logic [FIFO_AW+1:0] occ_ub;                 // upper bound on the fill level of C
   logic [FIFO_AW+1:0] occ_base;
   logic [FIFO_AW+1:0] committed;

   assign a_zero     = (i_head_a == '0);
   assign b_zero     = (i_head_b == '0);
   assign a_lte_b    = (i_head_a <= i_head_b);
   assign both_avail = !i_stat_a.empty && !i_stat_b.empty;
   assign run_end    = a_zero && b_zero;

   // a zero head waits for the other side to finish its run
   always_comb begin
      if (run_end) begin
         take_a = 1'b1;                        // head A is the zero that goes out
      end else if (a_zero) begin
         take_a = 1'b0;
      end else if (b_zero) begin
         take_a = 1'b1;
      end else begin
         take_a = a_lte_b;                     // ties go to A
      end
   end

   // C only reports empty and full, so the control keeps its own bound on the fill level
   // An empty C resets the bound, every write that lands raises it
   assign occ_base  = i_stat_c.empty ? '0 : occ_ub;
   assign committed = occ_base + s1_busy + s2_busy;
   assign near_full = i_stat_c.full || (committed >= (FIFO_AW + 2)'(FIFO_DEPTH));

   assign stall = !both_avail || !i_ready_q || near_full;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         s1_busy <= 1'b0;
         s2_busy <= 1'b0;
         occ_ub  <= '0;
      end else begin
         s1_busy <= !stall;
         s2_busy <= s1_busy;
         occ_ub  <= occ_base + s2_busy;
      end
   end

   assign o_ctrl.take_a  = take_a;
   assign o_ctrl.stall   = stall;
   assign o_ctrl.run_end = run_end;

   // at the end of a run both zeros leave together
   assign o_deq_a = !stall && take_a;
   assign o_deq_b = !stall && (!take_a || run_end);

endmodule

//--- merger/merge_network.sv
module merge_network
   import merge_pkg::*;
(
   input  logic        i_clk,
   input  logic        i_rst_n,
   input  merge_ctrl_t i_ctrl,
   input  key_t        i_head_a,
   input  key_t        i_head_b,
   output key_t        o_key,
   output logic        o_write
);

   key_t route_key;
   key_t key_s1;
   key_t key_s2;
   logic vld_s1;
   logic vld_s2;

   // route the chosen head, the end of a run always sends a clean zero
   always_comb begin
      unique case ({i_ctrl.run_end, i_ctrl.take_a})
         2'b00:   route_key = i_head_b;
         2'b01:   route_key = i_head_a;
         default: route_key = '0;
      endcase
   end

   // stage 1 captures the key only when the control lets a word go
   always_ff @(posedge i_clk) begin
      if (!i_ctrl.stall) begin
         key_s1 <= route_key;
      end
      key_s2 <= key_s1;                        // stage 2 lines up with the enqueue into C
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         vld_s1 <= 1'b0;
         vld_s2 <= 1'b0;
      end else begin
         vld_s1 <= !i_ctrl.stall;
         vld_s2 <= vld_s1;
      end
   end

   // two cycles after the decision the word is written into C
   assign o_key   = key_s2;
   assign o_write = vld_s2;

endmodule

//--- merger/merger.sv
module merger
   import merge_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_rst_n,
   input  key_t       i_a_data,
   input  key_t       i_b_data,
   input  fifo_stat_t i_a_stat,
   input  fifo_stat_t i_b_stat,
   output logic       o_a_read,
   output logic       o_b_read,
   input  logic       i_out_ready,
   input  logic       i_out_deq,
   output key_t       o_out_data,
   output fifo_stat_t o_out_stat
);

   key_t        a_head;
   key_t        b_head;
   fifo_stat_t  a_stat;
   fifo_stat_t  b_stat;
   fifo_stat_t  c_stat;
   merge_ctrl_t ctrl;
   logic        deq_a;
   logic        deq_b;
   key_t        net_key;
   logic        net_write;
   logic        ready_q;

   // a word moves from the source into A or B as soon as there is room
   assign o_a_read = !i_a_stat.empty && !a_stat.full;
   assign o_b_read = !i_b_stat.empty && !b_stat.full;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= i_out_ready;               // the control works from last cycle's ready
      end
   end

   sort_fifo fifo_a (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_enq   (o_a_read),
      .i_data  (i_a_data),
      .i_deq   (deq_a),
      .o_data  (a_head),
      .o_stat  (a_stat)
   );

   sort_fifo fifo_b (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_enq   (o_b_read),
      .i_data  (i_b_data),
      .i_deq   (deq_b),
      .o_data  (b_head),
      .o_stat  (b_stat)
   );

   merge_control merge_control_i (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_head_a  (a_head),
      .i_head_b  (b_head),
      .i_stat_a  (a_stat),
      .i_stat_b  (b_stat),
      .i_stat_c  (c_stat),
      .i_ready_q (ready_q),
      .o_ctrl    (ctrl),
      .o_deq_a   (deq_a),
      .o_deq_b   (deq_b)
   );

   merge_network merge_network_i (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_ctrl   (ctrl),
      .i_head_a (a_head),
      .i_head_b (b_head),
      .o_key    (net_key),
      .o_write  (net_write)
   );

   // C holds the merged run for the next level
   sort_fifo fifo_c (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_enq   (net_write),
      .i_data  (net_key),
      .i_deq   (i_out_deq),
      .o_data  (o_out_data),
      .o_stat  (c_stat)
   );

   assign o_out_stat = c_stat;

endmodule

//--- design/merge_tree_top.sv
module merge_tree_top
   import merge_pkg::*;
(
   input  logic               i_clk,
   input  logic               i_rst_n,
   input  logic [N_LANES-1:0] i_lane_wr,
   input  key_t               i_lane_data [N_LANES],
   output logic [N_LANES-1:0] o_lane_full,
   input  logic               i_out_ready,
   output logic               o_out_valid,
   output key_t               o_out_data
);

   key_t               lane_head [N_LANES];
   fifo_stat_t         lane_stat [N_LANES];
   logic [N_LANES-1:0] lane_read;
   key_t               leaf_data [2];
   fifo_stat_t         leaf_stat [2];
   logic [1:0]         leaf_ready;
   logic [1:0]         root_read;
   fifo_stat_t         root_stat;
   logic               ready_q;

   for (genvar n = 0; n < N_LANES; n++) begin : g_lane
      sort_fifo lane_fifo (
         .i_clk   (i_clk),
         .i_rst_n (i_rst_n),
         .i_enq   (i_lane_wr[n]),
         .i_data  (i_lane_data[n]),
         .i_deq   (lane_read[n]),
         .o_data  (lane_head[n]),
         .o_stat  (lane_stat[n])
      );
      assign o_lane_full[n] = lane_stat[n].full;
   end

   // leaf l merges lanes 2l and 2l+1
   for (genvar l = 0; l < 2; l++) begin : g_leaf
      merger leaf (
         .i_clk       (i_clk),
         .i_rst_n     (i_rst_n),
         .i_a_data    (lane_head[2*l]),
         .i_b_data    (lane_head[2*l+1]),
         .i_a_stat    (lane_stat[2*l]),
         .i_b_stat    (lane_stat[2*l+1]),
         .o_a_read    (lane_read[2*l]),
         .o_b_read    (lane_read[2*l+1]),
         .i_out_ready (leaf_ready[l]),
         .i_out_deq   (root_read[l]),
         .o_out_data  (leaf_data[l]),
         .o_out_stat  (leaf_stat[l])
      );
      assign leaf_ready[l] = root_read[l] || leaf_stat[l].empty; // root input has room
   end

   merger root (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_a_data    (leaf_data[0]),
      .i_b_data    (leaf_data[1]),
      .i_a_stat    (leaf_stat[0]),
      .i_b_stat    (leaf_stat[1]),
      .o_a_read    (root_read[0]),
      .o_b_read    (root_read[1]),
      .i_out_ready (i_out_ready),
      .i_out_deq   (o_out_valid),
      .o_out_data  (o_out_data),
      .o_out_stat  (root_stat)
   );

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= i_out_ready;
      end
   end

   // a word leaves the root on every edge where valid is high
   assign o_out_valid = !root_stat.empty && ready_q;

endmodule

//--- sim/merge_tree_checker.sv
module merge_tree_checker
   import merge_pkg::*;
(
   input logic       i_clk,
   input logic       i_rst_n,
   input logic       i_enq_a,
   input logic       i_enq_b,
   input logic       i_enq_c,
   input logic       i_deq_a,
   input logic       i_deq_b,
   input logic       i_deq_c,
   input fifo_stat_t i_stat_a,
   input fifo_stat_t i_stat_b,
   input fifo_stat_t i_stat_c,
   input key_t       i_key_c
);

   timeunit 1ns;
   timeprecision 100ps;

   key_t last_key;                             // last word written into C
   int   fail_count = 0;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         last_key <= '0;
      end else if (i_enq_c) begin
         last_key <= i_key_c;                  // a zero restarts the order for the next run
      end
   end

   no_deq_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !((i_deq_a && i_stat_a.empty) || (i_deq_b && i_stat_b.empty) || (i_deq_c && i_stat_c.empty)))
      else begin
         $error("dequeue of an empty merger FIFO");
         fail_count++;
      end

   no_enq_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !((i_enq_a && i_stat_a.full) || (i_enq_b && i_stat_b.full) || (i_enq_c && i_stat_c.full)))
      else begin
         $error("enqueue into a full merger FIFO");
         fail_count++;
      end

   c_ordered: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (i_enq_c && (i_key_c != '0)) |-> (i_key_c >= last_key))
      else begin
         $error("merged run written into FIFO C is out of order");
         fail_count++;
      end

endmodule

bind merger merge_tree_checker merge_tree_checker_i (
   .i_clk    (i_clk),
   .i_rst_n  (i_rst_n),
   .i_enq_a  (o_a_read),
   .i_enq_b  (o_b_read),
   .i_enq_c  (net_write),
   .i_deq_a  (deq_a),
   .i_deq_b  (deq_b),
   .i_deq_c  (i_out_deq),
   .i_stat_a (a_stat),
   .i_stat_b (b_stat),
   .i_stat_c (c_stat),
   .i_key_c  (net_key)
);

//--- sim/merge_tree_tb.sv
module merge_tree_tb
   import merge_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD = 40;
   localparam int N_TAB = 6;                   // hand-written rounds
   localparam int N_RAND = 12;                 // random rounds, four keys in every lane
   localparam int N_ROUNDS = N_TAB + N_RAND;

   // first key in slot 3, unused slots hold zero
   typedef logic [3:0][KEY_W-1:0] lane_keys_t;

   logic               i_clk;
   logic               i_rst_n;
   logic [N_LANES-1:0] i_lane_wr;
   key_t               i_lane_data [N_LANES];
   logic [N_LANES-1:0] o_lane_full;
   logic               i_out_ready;
   logic               o_out_valid;
   key_t               o_out_data;

   lane_keys_t round_tab [N_ROUNDS][N_LANES];
   key_t       exp_q[$];
   integer     seed;
   int         total_words;
   int         out_count;
   int         checks;
   int         errors;
   int         assert_fails;
   int         full_waits;
   logic       hold_ready_low;

   merge_tree_top merge_tree_top_i (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_lane_wr   (i_lane_wr),
      .i_lane_data (i_lane_data),
      .o_lane_full (o_lane_full),
      .i_out_ready (i_out_ready),
      .o_out_valid (o_out_valid),
      .o_out_data  (o_out_data)
   );

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   task automatic check_value(input logic [KEY_W-1:0] actual, input logic [KEY_W-1:0] expected,
                              input string what);
      checks++;
      if (actual !== expected) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         errors++;
      end
   endtask

   task automatic load_table();
      round_tab[0][0] = {32'd3, 32'd7, 32'd9, 32'd12};
      round_tab[0][1] = {32'd1, 32'd5, 32'd0, 32'd0};
      round_tab[0][2] = {32'd2, 32'd8, 32'd20, 32'd0};
      round_tab[0][3] = {32'd4, 32'd6, 32'd10, 32'd11};
      round_tab[1][0] = '0;
      round_tab[1][1] = {32'd15, 32'd0, 32'd0, 32'd0};
      round_tab[1][2] = '0;
      round_tab[1][3] = '0;
      round_tab[2][0] = {32'd5, 32'd5, 32'd9, 32'd0};
      round_tab[2][1] = {32'd5, 32'd9, 32'd0, 32'd0};
      round_tab[2][2] = {32'd1, 32'd5, 32'd0, 32'd0};
      round_tab[2][3] = {32'd9, 32'd9, 32'd9, 32'd9};
      round_tab[3][0] = '0;                    // a round of empty runs only
      round_tab[3][1] = '0;
      round_tab[3][2] = '0;
      round_tab[3][3] = '0;
      round_tab[4][0] = {32'hffff_fffe, 32'hffff_ffff, 32'h0, 32'h0};
      round_tab[4][1] = {32'h1, 32'h0, 32'h0, 32'h0};
      round_tab[4][2] = {32'h8000_0000, 32'h8000_0001, 32'h0, 32'h0};
      round_tab[4][3] = {32'h7fff_ffff, 32'h0, 32'h0, 32'h0};
      round_tab[5][0] = {32'd10, 32'd20, 32'd30, 32'd40};
      round_tab[5][1] = '0;
      round_tab[5][2] = '0;
      round_tab[5][3] = {32'd11, 32'd21, 32'd31, 32'd41};
   endtask

   task automatic add_random_rounds();
      key_t k;
      for (int r = N_TAB; r < N_ROUNDS; r++) begin
         for (int n = 0; n < N_LANES; n++) begin
            k = key_t'(1 + ($random(seed) & 32'h3ff));
            for (int s = 3; s >= 0; s--) begin
               round_tab[r][n][s] = k;
               k = k + key_t'($random(seed) & 32'h3f); // a zero step gives a duplicate
            end
         end
      end
   endtask

   function automatic int count_words();
      int words;
      words = N_ROUNDS * N_LANES;              // one zero per lane and round
      for (int r = 0; r < N_ROUNDS; r++) begin
         for (int n = 0; n < N_LANES; n++) begin
            for (int s = 3; s >= 0 && round_tab[r][n][s] != '0; s--) begin
               words++;
            end
         end
      end
      return words;
   endfunction

   // all keys of the round in ascending order, then a single zero
   task automatic push_expected(input int r);
      key_t vals [4 * N_LANES];
      key_t k;
      int   cnt;
      int   j;
      cnt = 0;
      for (int n = 0; n < N_LANES; n++) begin
         for (int s = 3; s >= 0 && round_tab[r][n][s] != '0; s--) begin
            k = round_tab[r][n][s];
            j = cnt;
            while (j > 0 && vals[j-1] > k) begin
               vals[j] = vals[j-1];
               j--;
            end
            vals[j] = k;
            cnt++;
         end
      end
      for (int i = 0; i < cnt; i++) begin
         exp_q.push_back(vals[i]);
      end
      exp_q.push_back('0);
   endtask

   task automatic write_word(input int lane, input key_t key);
      @(negedge i_clk);
      if (o_lane_full[lane]) begin
         full_waits++;
         hold_ready_low = 1'b0;                // let the tree drain again
      end
      while (o_lane_full[lane]) begin
         @(negedge i_clk);
      end
      @(posedge i_clk);
      i_lane_wr[lane] <= 1'b1;
      i_lane_data[lane] <= key;
      @(posedge i_clk);
      i_lane_wr[lane] <= 1'b0;
   endtask

   task automatic write_round(input int r);
      for (int n = 0; n < N_LANES; n++) begin
         for (int s = 3; s >= 0 && round_tab[r][n][s] != '0; s--) begin
            write_word(n, round_tab[r][n][s]);
         end
         write_word(n, '0);
      end
   endtask

   always @(posedge i_clk) begin
      if (!i_rst_n || hold_ready_low) begin
         i_out_ready <= 1'b0;
      end else begin
         i_out_ready <= ($random(seed) & 1) != 0;
      end
   end

   always @(negedge i_clk) begin
      if (!i_rst_n) begin
         check_value(o_out_valid, 1'b0, "o_out_valid during reset");
         check_value(o_lane_full, '0, "o_lane_full during reset");
      end else if (o_out_valid) begin
         if (exp_q.size() == 0) begin
            $display("An extra output word %h appeared at %0t ns after the last expected word",
                     o_out_data, $time);
            errors++;
         end else begin
            check_value(o_out_data, exp_q.pop_front(), $sformatf("output word %0d", out_count));
         end
         out_count++;
      end
   end

   initial begin
      wait (total_words > 0);
      repeat (total_words * 200) begin
         @(posedge i_clk);
      end
      $display("Timeout: the merged stream did not finish, %0d words still expected", exp_q.size());
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Finished with errors");
      $finish;
   end

   initial begin
      i_rst_n = 1'b0;
      i_lane_wr = '0;
      for (int n = 0; n < N_LANES; n++) begin
         i_lane_data[n] = '0;
      end
      i_out_ready = 1'b0;
      hold_ready_low = 1'b0;
      out_count = 0;
      checks = 0;
      errors = 0;
      full_waits = 0;
      seed = 32'hf1ad680a;
      load_table();
      add_random_rounds();
      total_words = count_words();
      repeat (8) begin
         @(posedge i_clk);
      end
      i_rst_n <= 1'b1;
      repeat (3) begin
         @(negedge i_clk);
         check_value(o_out_valid, 1'b0, "o_out_valid after reset");
         check_value(o_lane_full, '0, "o_lane_full after reset");
      end
      for (int r = 0; r < N_ROUNDS; r++) begin
         if (r == N_TAB) begin
            @(negedge i_clk);
            hold_ready_low = 1'b1;             // root stalls until some lane fills up
         end
         push_expected(r);
         write_round(r);
      end
      @(negedge i_clk);
      hold_ready_low = 1'b0;
      while (exp_q.size() != 0) begin
         @(negedge i_clk);
      end
      repeat (20) begin
         @(negedge i_clk);
      end
      if (full_waits == 0) begin
         $display("The lane FIFOs never reported full, so the writer was never throttled");
         errors++;
      end
      assert_fails = merge_tree_top_i.g_leaf[0].leaf.merge_tree_checker_i.fail_count
                   + merge_tree_top_i.g_leaf[1].leaf.merge_tree_checker_i.fail_count
                   + merge_tree_top_i.root.merge_tree_checker_i.fail_count;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- verilog.f
common/merge_pkg.sv
design/sort_fifo.sv
merger/merge_control.sv
merger/merge_network.sv
merger/merger.sv
design/merge_tree_top.sv
sim/merge_tree_checker.sv
sim/merge_tree_tb.sv

//--- Bender.yml
package:
  name: merge_tree

sources:
  - common/merge_pkg.sv
  - design/sort_fifo.sv
  - merger/merge_control.sv
  - merger/merge_network.sv
  - merger/merger.sv
  - design/merge_tree_top.sv
  - target: simulation
    files:
      - sim/merge_tree_checker.sv
      - sim/merge_tree_tb.sv
